// ==== hdl/lockstep_sync_pkg.sv ====
// Shared constants, types and state encodings for the lockstep sync controller
package lockstep_sync_pkg;

  // Majority vote only works for three harts
  localparam int NUM_HARTS = 3;

  // Halt acknowledgements the master needs before it moves on
  localparam int HALT_QUORUM = 2;

  // One bit per hart
  typedef logic [NUM_HARTS-1:0] hart_vec_t;

  // Mode state machine
  typedef enum logic [1:0] {
    MODE_RESET,
    MODE_IDLE,
    MODE_TRIPLE,
    MODE_DUAL
  } mode_state_e;

  // Per-hart synchronization state machine
  typedef enum logic [2:0] {
    SYNC_RESET,
    SYNC_IDLE,
    SYNC_HALT_REQ,
    SYNC_WAIT_WFI,
    SYNC_INTR_SYNC,
    SYNC_IN_SYNC,
    SYNC_END_SYNC
  } sync_state_e;

  // Status levels coming back from the cores
  typedef struct packed {
    hart_vec_t halt_ack;
    hart_vec_t wfi;
    hart_vec_t intc_ack;
    hart_vec_t master;
  } hart_status_t;

  // Outputs of one hart machine towards the mode controller
  typedef struct packed {
    logic idle;
    logic halt_req;
    logic sync_irq;
    logic lockstep;
  } hart_req_t;

  typedef hart_req_t [NUM_HARTS-1:0] hart_req_vec_t;

endpackage

// ==== hdl/safe_mode_ctrl.sv ====
// Mode state machine of the lockstep controller; merges the hart requests into core outputs
`timescale 1ns/1ns

module safe_mode_ctrl
  import lockstep_sync_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          safe_mode_i,
  input  logic          tmr_config_i,
  input  hart_vec_t     master_i,
  input  hart_req_vec_t hart_req_i,
  output mode_state_e   mode_o,
  output logic          halt_broadcast_o,
  output hart_vec_t     halt_irq_o,
  output hart_vec_t     sync_irq_o,
  output logic          single_bus_o,
  output logic          voter_enable_o,
  output logic          ext_debug_en_o
);

  mode_state_e state_q;
  mode_state_e state_d;

  logic      all_idle;
  logic      any_halt_req;
  logic      any_lockstep;
  hart_vec_t sync_irq;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= MODE_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      MODE_RESET:
      begin
        state_d = MODE_IDLE;
      end
      MODE_IDLE:
      begin
        if (safe_mode_i && tmr_config_i)
          state_d = MODE_TRIPLE;
        else if (safe_mode_i)
          state_d = MODE_DUAL;
      end
      MODE_TRIPLE:
      begin
        // Harts must finish their ending handshake first
        if (!safe_mode_i && all_idle)
          state_d = MODE_IDLE;
      end
      MODE_DUAL:
      begin
        if (!safe_mode_i)
          state_d = MODE_IDLE;
      end
      default:
      begin
        state_d = MODE_IDLE;
      end
    endcase
  end

  // Merge the per-hart requests
  always_comb
  begin
    all_idle     = 1'b1;
    any_halt_req = 1'b0;
    any_lockstep = 1'b0;
    sync_irq     = '0;
    for (int i = 0; i < NUM_HARTS; i++)
    begin
      all_idle     = all_idle & hart_req_i[i].idle;
      any_halt_req = any_halt_req | hart_req_i[i].halt_req;
      any_lockstep = any_lockstep | hart_req_i[i].lockstep;
      sync_irq[i]  = hart_req_i[i].sync_irq;
    end
  end

  assign mode_o           = state_q;
  assign halt_broadcast_o = any_halt_req;
  assign sync_irq_o       = sync_irq;

  // Halt every hart except the master
  assign halt_irq_o = any_halt_req ? ~master_i : '0;

  // Bus and voter always switch together
  assign single_bus_o   = any_lockstep;
  assign voter_enable_o = any_lockstep;

  assign ext_debug_en_o = (state_q == MODE_IDLE);

endmodule

// ==== hdl/hart_sync_fsm.sv ====
// Synchronization state machine for one lockstep hart; instantiated once per hart by the top
`timescale 1ns/1ns

module hart_sync_fsm
  import lockstep_sync_pkg::*;
#(
  parameter int HART_IDX = 0
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         safe_mode_i,
  input  logic         initial_sync_i,
  input  mode_state_e  mode_i,
  input  logic         halt_broadcast_i,
  input  hart_status_t status_i,
  output hart_req_t    req_o
);

  sync_state_e state_q;
  sync_state_e state_d;

  logic is_master;
  logic quorum_met;
  logic all_wfi;
  logic all_intc_ack;

  assign is_master    = status_i.master[HART_IDX];
  assign quorum_met   = ($countones(status_i.halt_ack) >= HALT_QUORUM);
  assign all_wfi      = &status_i.wfi;
  assign all_intc_ack = &status_i.intc_ack;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= SYNC_RESET;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      SYNC_RESET:
      begin
        state_d = SYNC_IDLE;
      end
      SYNC_IDLE:
      begin
        if (mode_i == MODE_TRIPLE && safe_mode_i)
        begin
          // Master starts on request, the others follow its halt
          if (is_master && initial_sync_i)
            state_d = SYNC_HALT_REQ;
          else if (!is_master && halt_broadcast_i)
            state_d = SYNC_HALT_REQ;
        end
      end
      SYNC_HALT_REQ:
      begin
        if (is_master && quorum_met)
          state_d = SYNC_WAIT_WFI;
        else if (!is_master && status_i.halt_ack[HART_IDX])
          state_d = SYNC_WAIT_WFI;
      end
      SYNC_WAIT_WFI:
      begin
        if (all_wfi)
          state_d = SYNC_INTR_SYNC;
      end
      SYNC_INTR_SYNC:
      begin
        if (all_intc_ack)
          state_d = SYNC_IN_SYNC;
      end
      SYNC_IN_SYNC:
      begin
        if (all_wfi && !safe_mode_i)
          state_d = SYNC_END_SYNC;
      end
      SYNC_END_SYNC:
      begin
        if (is_master && status_i.intc_ack[HART_IDX])
          state_d = SYNC_IDLE;
        else if (!is_master && status_i.wfi[HART_IDX])
          state_d = SYNC_IDLE;
      end
      default:
      begin
        state_d = SYNC_IDLE;
      end
    endcase
  end

  // Outputs depend on state and the master bit only
  always_comb
  begin
    req_o = '0;
    unique case (state_q)
      SYNC_IDLE:
      begin
        req_o.idle = 1'b1;
      end
      SYNC_HALT_REQ:
      begin
        req_o.halt_req = is_master;
      end
      SYNC_INTR_SYNC:
      begin
        req_o.sync_irq = 1'b1;
        req_o.lockstep = 1'b1;
      end
      SYNC_IN_SYNC:
      begin
        req_o.lockstep = 1'b1;
      end
      SYNC_END_SYNC:
      begin
        // Master gets one more interrupt to leave lockstep
        req_o.sync_irq = is_master;
      end
      default:
      begin
        req_o = '0;
      end
    endcase
  end

endmodule

// ==== hdl/lockstep_sync_top.sv ====
// Top level of the lockstep sync controller; connects the mode controller to the hart machines
`timescale 1ns/1ns

module lockstep_sync_top
  import lockstep_sync_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         safe_mode_i,
  input  logic         tmr_config_i,
  input  logic         initial_sync_i,
  input  hart_status_t status_i,
  output hart_vec_t    sync_irq_o,
  output hart_vec_t    halt_irq_o,
  output logic         single_bus_o,
  output logic         voter_enable_o,
  output logic         ext_debug_en_o
);

  mode_state_e   mode;
  logic          halt_broadcast;
  hart_req_vec_t hart_req;

  safe_mode_ctrl i_mode (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .safe_mode_i      (safe_mode_i),
    .tmr_config_i     (tmr_config_i),
    .master_i         (status_i.master),
    .hart_req_i       (hart_req),
    .mode_o           (mode),
    .halt_broadcast_o (halt_broadcast),
    .halt_irq_o       (halt_irq_o),
    .sync_irq_o       (sync_irq_o),
    .single_bus_o     (single_bus_o),
    .voter_enable_o   (voter_enable_o),
    .ext_debug_en_o   (ext_debug_en_o)
  );

  // One sync machine per hart
  for (genvar i = 0; i < NUM_HARTS; i++)
  begin : g_hart
    hart_sync_fsm #(
      .HART_IDX (i)
    ) i_hart_sync (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .safe_mode_i      (safe_mode_i),
      .initial_sync_i   (initial_sync_i),
      .mode_i           (mode),
      .halt_broadcast_i (halt_broadcast),
      .status_i         (status_i),
      .req_o            (hart_req[i])
    );
  end

endmodule

// ==== tests/tb_clock_gen.sv ====
// Clock and power-on reset source for the lockstep sync testbench
`timescale 1ns/1ns

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release just after a rising edge
  initial
  begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

// ==== tests/lockstep_sync_tests.svh ====
// Directed test tasks for the lockstep sync controller, included by the testbench top

// Master starts the halt phase
task automatic enter_triple();
  drive_edge();
  status.master = cur_mask;
  tmr_config    = 1'b1;
  safe_mode     = 1'b1;
  initial_sync  = 1'b1;
  wait_for(WAIT_HALT_ON);
  check_vec("halt_irq_o", ~cur_mask, halt_irq);
  check_bit("ext_debug_en_o", 1'b0, debug_en);
  drive_edge();
  initial_sync = 1'b0;
endtask

// From the end of the halt phase up to running in step
task automatic run_to_sync();
  drive_edge();
  status.wfi = '1;
  wait_for(WAIT_SYNC_ON);
  check_vec("sync_irq_o", '1, sync_irq);
  check_bit("single_bus_o", 1'b1, single_bus);
  check_bit("voter_enable_o", 1'b1, voter_enable);
  drive_edge();
  status.intc_ack = '1;
  status.wfi      = '0;
  status.halt_ack = '0;
  wait_for(WAIT_SYNC_OFF);
  check_bit("single_bus_o", 1'b1, single_bus);
  check_bit("voter_enable_o", 1'b1, voter_enable);
  drive_edge();
  status.intc_ack = '0;
endtask

task automatic exit_lockstep();
  drive_edge();
  safe_mode  = 1'b0;
  status.wfi = '1;
  wait_for(WAIT_BUS_OFF);
  check_vec("sync_irq_o", cur_mask, sync_irq);
  check_bit("voter_enable_o", 1'b0, voter_enable);
  // Master has not acknowledged yet
  repeat (3)
  begin
    @(negedge clk);
    check_vec("sync_irq_o", cur_mask, sync_irq);
    check_bit("ext_debug_en_o", 1'b0, debug_en);
  end
  drive_edge();
  status.intc_ack = cur_mask;
  wait_for(WAIT_DEBUG_EN);
  check_vec("sync_irq_o", '0, sync_irq);
  check_bit("single_bus_o", 1'b0, single_bus);
  drive_edge();
  status     = '0;
  tmr_config = 1'b0;
endtask

task automatic test_reset();
  int start_errors;
  start_errors = error_count;
  @(negedge clk);
  check_bit("ext_debug_en_o", 1'b0, debug_en);
  @(negedge clk);
  check_bit("ext_debug_en_o", 1'b1, debug_en);
  check_vec("halt_irq_o", '0, halt_irq);
  check_vec("sync_irq_o", '0, sync_irq);
  check_bit("single_bus_o", 1'b0, single_bus);
  check_bit("voter_enable_o", 1'b0, voter_enable);
  end_test("reset", start_errors);
endtask

// A master with a sync request must stay quiet outside triple mode
task automatic test_dual_mode();
  int start_errors;
  start_errors = error_count;
  drive_edge();
  tmr_config    = 1'b0;
  safe_mode     = 1'b1;
  status.master = hart_vec_t'(1);
  initial_sync  = 1'b1;
  repeat (2) @(negedge clk);
  check_bit("ext_debug_en_o", 1'b0, debug_en);
  repeat (6)
  begin
    @(negedge clk);
    check_vec("halt_irq_o", '0, halt_irq);
    check_vec("sync_irq_o", '0, sync_irq);
    check_bit("single_bus_o", 1'b0, single_bus);
    check_bit("voter_enable_o", 1'b0, voter_enable);
  end
  drive_edge();
  safe_mode    = 1'b0;
  initial_sync = 1'b0;
  status       = '0;
  wait_for(WAIT_DEBUG_EN);
  end_test("dual mode", start_errors);
endtask

task automatic test_triple_sync();
  int start_errors;
  start_errors = error_count;
  cur_mask = pick_master();
  enter_triple();
  drive_edge();
  status.halt_ack = ~cur_mask;
  wait_for(WAIT_HALT_OFF);
  run_to_sync();
  end_test("triple sync", start_errors);
endtask

task automatic test_quorum();
  int        start_errors;
  hart_vec_t others;
  hart_vec_t first_ack;
  start_errors = error_count;
  exit_lockstep();
  cur_mask  = pick_master();
  others    = ~cur_mask;
  first_ack = others & ~(others - 3'd1);
  enter_triple();
  drive_edge();
  status.halt_ack = first_ack;
  repeat (10)
  begin
    @(negedge clk);
    check_vec("halt_irq_o", ~cur_mask, halt_irq);
  end
  drive_edge();
  status.halt_ack = others;
  wait_for(WAIT_HALT_OFF);
  run_to_sync();
  end_test("halt quorum", start_errors);
endtask

task automatic test_exit();
  int start_errors;
  start_errors = error_count;
  exit_lockstep();
  end_test("exit", start_errors);
endtask

// ==== tests/lockstep_sync_tb.sv ====
// Testbench top for the lockstep sync controller; compile with the project file list
`timescale 1ns/1ns

module lockstep_sync_tb
  import lockstep_sync_pkg::*;
();

  localparam int CLK_PERIOD  = 4;
  localparam int MAX_WAIT    = 64;
  localparam int NUM_TESTS   = 5;
  localparam int WATCHDOG_NS = NUM_TESTS * MAX_WAIT * CLK_PERIOD;

  typedef enum {
    WAIT_DEBUG_EN,
    WAIT_HALT_ON,
    WAIT_HALT_OFF,
    WAIT_SYNC_ON,
    WAIT_SYNC_OFF,
    WAIT_BUS_OFF
  } wait_e;

  logic         clk;
  logic         rst_n;
  logic         safe_mode;
  logic         tmr_config;
  logic         initial_sync;
  hart_status_t status;
  hart_vec_t    sync_irq;
  hart_vec_t    halt_irq;
  logic         single_bus;
  logic         voter_enable;
  logic         debug_en;

  logic [7:0] lfsr_q;
  hart_vec_t  cur_mask;
  int         error_count;
  int         failed_tests;

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD),
    .RESET_CYCLES (5)
  ) i_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  lockstep_sync_top i_dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .safe_mode_i    (safe_mode),
    .tmr_config_i   (tmr_config),
    .initial_sync_i (initial_sync),
    .status_i       (status),
    .sync_irq_o     (sync_irq),
    .halt_irq_o     (halt_irq),
    .single_bus_o   (single_bus),
    .voter_enable_o (voter_enable),
    .ext_debug_en_o (debug_en)
  );

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
    lfsr_q = {lfsr_q[6:0], fb};
    return fb;
  endfunction

  function automatic hart_vec_t pick_master();
    logic [1:0] bits;
    bits[1] = lfsr_step();
    bits[0] = lfsr_step();
    return hart_vec_t'(1) << (bits % 3);
  endfunction

  task automatic check_vec(input string name, input hart_vec_t expected, input hart_vec_t actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected)
    begin
      $display("[ERROR] %0t ns %s expected %b got %b", $time, name, expected, actual);
      error_count++;
    end
  endtask

  function automatic logic reached(input wait_e w);
    case (w)
      WAIT_DEBUG_EN: return debug_en === 1'b1;
      WAIT_HALT_ON:  return halt_irq !== '0;
      WAIT_HALT_OFF: return halt_irq === '0;
      WAIT_SYNC_ON:  return sync_irq !== '0;
      WAIT_SYNC_OFF: return sync_irq === '0;
      WAIT_BUS_OFF:  return single_bus === 1'b0;
      default:       return 1'b0;
    endcase
  endfunction

  // Polls on falling edges, where outputs are settled
  task automatic wait_for(input wait_e w);
    int n;
    n = 0;
    do
    begin
      @(negedge clk);
      n++;
    end
    while (!reached(w) && n < MAX_WAIT);
    if (!reached(w))
    begin
      $display("Timed out after %0d cycles waiting for %s", MAX_WAIT, w.name());
      error_count++;
    end
  endtask

  task automatic drive_edge();
    @(posedge clk);
    #1;
  endtask

  task automatic end_test(input string name, input int start_errors);
    if (error_count == start_errors)
    begin
      $display("%0t ns  %s: ok", $time, name);
    end
    else
    begin
      failed_tests++;
      $display("%0t ns  %s: failed with %0d errors", $time, name, error_count - start_errors);
    end
  endtask

  `include "lockstep_sync_tests.svh"

  initial
  begin
    safe_mode    = 1'b0;
    tmr_config   = 1'b0;
    initial_sync = 1'b0;
    status       = '0;
    lfsr_q       = 8'd84;
    cur_mask     = '0;
    error_count  = 0;
    failed_tests = 0;
    @(posedge rst_n);
    test_reset();
    test_dual_mode();
    test_triple_sync();
    test_quorum();
    test_exit();
    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests, error_count);
    if (error_count == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== lockstep_sync.f ====
+incdir+tests
hdl/lockstep_sync_pkg.sv
hdl/safe_mode_ctrl.sv
hdl/hart_sync_fsm.sv
hdl/lockstep_sync_top.sv
tests/tb_clock_gen.sv
tests/lockstep_sync_tb.sv
